//--- common/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Memory, accumulator and I/O word width
`define CPU_DATA_WIDTH 16

// Memory address and program counter width
`define CPU_ADDR_WIDTH 6

// Direct operand address held in an instruction field
`define CPU_OPND_ADDR_WIDTH 3

// Address of the first instruction after reset
`define CPU_RESET_PC 6'd8

`endif

//--- common/cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

    typedef enum logic [3:0] {
        op_mov  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_mul  = 4'd3,
        op_in   = 4'd7,
        op_out  = 4'd8,
        op_stop = 4'd15
    } opcode_e;

    // One operand field, with indirect flag on top
    typedef struct packed {
        logic                            indirect;
        logic [`CPU_OPND_ADDR_WIDTH-1:0] addr;
    } operand_t;

    typedef struct packed {
        opcode_e  opcode;
        operand_t op1;
        operand_t op2;
        operand_t op3;
    } instr_ops_t;

    // Raw view, used for presence tests and the MOV mode
    typedef struct packed {
        opcode_e    opcode;
        logic [3:0] nib1;
        logic [3:0] nib2;
        logic [3:0] nib3;
    } instr_nibs_t;

    typedef union packed {
        instr_ops_t  ops;
        instr_nibs_t nibs;
    } instr_word_t;

    // MOV mode nibble encodings
    localparam logic [3:0] mov_mode_mem = 4'h0;
    localparam logic [3:0] mov_mode_imm = 4'h8;

    typedef enum logic [3:0] {
        fetch,
        fetch_wait,
        decode,
        op1_indirect,
        op2_indirect,
        op3_indirect,
        op1_ready,
        op2_ready,
        op3_ready,
        second_word,
        second_word_ready,
        stopped
    } state_e;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_mul
    } alu_op_e;

endpackage

//--- design/cpu_alu.sv
`include "cpu_settings.svh"

module cpu_alu (
    input  cpu_pkg::alu_op_e           op,
    input  logic [`CPU_DATA_WIDTH-1:0] a,
    input  logic [`CPU_DATA_WIDTH-1:0] b,
    output logic [`CPU_DATA_WIDTH-1:0] result
);

    // Results wrap to the word width
    always_comb begin
        case (op)
            cpu_pkg::alu_add: result = a + b;
            cpu_pkg::alu_sub: result = a - b;
            cpu_pkg::alu_mul: result = a * b;
            default:          result = a + b;
        endcase
    end

endmodule

//--- design/cpu_regs.sv
`include "cpu_settings.svh"

module cpu_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pc_inc,
    input  logic                       ir_ld,
    input  logic                       ir_low_ld,
    input  logic                       acc_ld,
    input  logic                       acc_from_alu,
    input  logic                       out_ld,
    input  logic [`CPU_DATA_WIDTH-1:0] mem_in,
    input  logic [`CPU_DATA_WIDTH-1:0] alu_result,
    output logic [`CPU_ADDR_WIDTH-1:0] pc,
    output cpu_pkg::instr_word_t       ir,
    output logic [`CPU_DATA_WIDTH-1:0] ir_low,
    output logic [`CPU_DATA_WIDTH-1:0] acc,
    output logic [`CPU_DATA_WIDTH-1:0] out
);

    logic [`CPU_DATA_WIDTH-1:0] acc_d;

    // Accumulator takes either a memory word or the ALU result
    assign acc_d = acc_from_alu ? alu_result : mem_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `CPU_RESET_PC;
        end else if (pc_inc) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir     <= '0;
            ir_low <= '0;
        end else begin
            if (ir_ld)
                ir <= mem_in;
            if (ir_low_ld)
                ir_low <= mem_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (acc_ld) begin
            acc <= acc_d;
        end
    end

    // Standard output word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out <= '0;
        end else if (out_ld) begin
            out <= mem_in;
        end
    end

endmodule

//--- control/cpu_control.sv
`include "cpu_settings.svh"

module cpu_control (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`CPU_ADDR_WIDTH-1:0] pc,
    input  cpu_pkg::instr_word_t       ir,
    input  logic [`CPU_DATA_WIDTH-1:0] ir_low,
    input  logic [`CPU_DATA_WIDTH-1:0] acc,
    input  logic [`CPU_DATA_WIDTH-1:0] mem_in,
    input  logic [`CPU_DATA_WIDTH-1:0] in,
    input  logic [`CPU_DATA_WIDTH-1:0] alu_result,
    output logic                       mem_we,
    output logic [`CPU_ADDR_WIDTH-1:0] mem_addr,
    output logic [`CPU_DATA_WIDTH-1:0] mem_data,
    output logic                       pc_inc,
    output logic                       ir_ld,
    output logic                       ir_low_ld,
    output logic                       acc_ld,
    output logic                       acc_from_alu,
    output logic                       out_ld,
    output cpu_pkg::alu_op_e           alu_op,
    output logic                       halted
);

    cpu_pkg::state_e            state;
    cpu_pkg::state_e            state_next;
    cpu_pkg::opcode_e           opcode;
    cpu_pkg::operand_t          op1;
    cpu_pkg::operand_t          op2;
    cpu_pkg::operand_t          op3;
    logic [`CPU_ADDR_WIDTH-1:0] ind_addr;
    logic                       mov_imm;
    logic [1:0]                 stop_after;
    logic [1:0]                 stop_idx;
    cpu_pkg::operand_t          stop_opnd;
    cpu_pkg::state_e            stop_state;

    function automatic logic [`CPU_ADDR_WIDTH-1:0] opnd_addr(input cpu_pkg::operand_t o);
        return {{(`CPU_ADDR_WIDTH-`CPU_OPND_ADDR_WIDTH){1'b0}}, o.addr};
    endfunction

    // Where to go after issuing the read of an operand address
    function automatic cpu_pkg::state_e rd_state(input cpu_pkg::operand_t o,
                                                 input cpu_pkg::state_e ind,
                                                 input cpu_pkg::state_e rdy);
        return o.indirect ? ind : rdy;
    endfunction

    // First present STOP operand after position "after", 0 when none is left
    function automatic logic [1:0] next_stop(input cpu_pkg::instr_word_t w,
                                             input logic [1:0] after);
        logic [1:0] idx;
        idx = 2'd0;
        if (after < 2'd3 && w.nibs.nib3 != 4'd0)
            idx = 2'd3;
        if (after < 2'd2 && w.nibs.nib2 != 4'd0)
            idx = 2'd2;
        if (after < 2'd1 && w.nibs.nib1 != 4'd0)
            idx = 2'd1;
        return idx;
    endfunction

    assign opcode   = ir.ops.opcode;
    assign op1      = ir.ops.op1;
    assign op2      = ir.ops.op2;
    assign op3      = ir.ops.op3;
    assign ind_addr = mem_in[`CPU_ADDR_WIDTH-1:0];
    assign mov_imm  = (ir.nibs.nib3 == cpu_pkg::mov_mode_imm);
    assign halted   = (state == cpu_pkg::stopped);

    always_comb begin
        case (state)
            cpu_pkg::op1_ready: stop_after = 2'd1;
            cpu_pkg::op2_ready: stop_after = 2'd2;
            default:            stop_after = 2'd0;
        endcase
        stop_idx = next_stop(ir, stop_after);
        case (stop_idx)
            2'd1: begin
                stop_opnd  = op1;
                stop_state = rd_state(op1, cpu_pkg::op1_indirect, cpu_pkg::op1_ready);
            end
            2'd2: begin
                stop_opnd  = op2;
                stop_state = rd_state(op2, cpu_pkg::op2_indirect, cpu_pkg::op2_ready);
            end
            2'd3: begin
                stop_opnd  = op3;
                stop_state = rd_state(op3, cpu_pkg::op3_indirect, cpu_pkg::op3_ready);
            end
            default: begin
                stop_opnd  = op3;
                stop_state = cpu_pkg::stopped;
            end
        endcase
    end

    always_comb begin
        case (opcode)
            cpu_pkg::op_sub: alu_op = cpu_pkg::alu_sub;
            cpu_pkg::op_mul: alu_op = cpu_pkg::alu_mul;
            default:         alu_op = cpu_pkg::alu_add;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cpu_pkg::fetch;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next   = state;
        mem_we       = 1'b0;
        mem_addr     = pc;
        mem_data     = '0;
        pc_inc       = 1'b0;
        ir_ld        = 1'b0;
        ir_low_ld    = 1'b0;
        acc_ld       = 1'b0;
        acc_from_alu = 1'b0;
        out_ld       = 1'b0;

        case (state)
            cpu_pkg::fetch: begin
                pc_inc     = 1'b1;
                state_next = cpu_pkg::fetch_wait;
            end
            cpu_pkg::fetch_wait: begin
                ir_ld      = 1'b1;
                state_next = cpu_pkg::decode;
            end
            cpu_pkg::decode: begin
                case (opcode)
                    cpu_pkg::op_mov: begin
                        if (ir.nibs.nib3 == cpu_pkg::mov_mode_mem) begin
                            mem_addr   = opnd_addr(op2);
                            state_next = rd_state(op2, cpu_pkg::op2_indirect, cpu_pkg::op2_ready);
                        end else if (mov_imm) begin
                            // Second word sits right after the instruction
                            pc_inc     = 1'b1;
                            state_next = cpu_pkg::second_word;
                        end else begin
                            state_next = cpu_pkg::fetch;
                        end
                    end
                    cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_mul: begin
                        mem_addr   = opnd_addr(op2);
                        state_next = rd_state(op2, cpu_pkg::op2_indirect, cpu_pkg::op2_ready);
                    end
                    cpu_pkg::op_in: begin
                        mem_addr = opnd_addr(op1);
                        if (op1.indirect) begin
                            state_next = cpu_pkg::op1_ready;
                        end else begin
                            mem_we     = 1'b1;
                            mem_data   = in;
                            state_next = cpu_pkg::fetch;
                        end
                    end
                    cpu_pkg::op_out: begin
                        mem_addr   = opnd_addr(op1);
                        state_next = rd_state(op1, cpu_pkg::op1_indirect, cpu_pkg::op1_ready);
                    end
                    cpu_pkg::op_stop: begin
                        mem_addr   = opnd_addr(stop_opnd);
                        state_next = stop_state;
                    end
                    default: state_next = cpu_pkg::fetch;
                endcase
            end
            // Pointer word is on mem_in, follow it
            cpu_pkg::op1_indirect: begin
                mem_addr   = ind_addr;
                state_next = cpu_pkg::op1_ready;
            end
            cpu_pkg::op2_indirect: begin
                mem_addr   = ind_addr;
                state_next = cpu_pkg::op2_ready;
            end
            cpu_pkg::op3_indirect: begin
                mem_addr   = ind_addr;
                state_next = cpu_pkg::op3_ready;
            end
            cpu_pkg::op1_ready: begin
                state_next = cpu_pkg::fetch;
                case (opcode)
                    cpu_pkg::op_in: begin
                        mem_we   = 1'b1;
                        mem_addr = ind_addr;
                        mem_data = in;
                    end
                    cpu_pkg::op_out: out_ld = 1'b1;
                    // Indirect destination, the value waits in acc or ir_low
                    cpu_pkg::op_mov, cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_mul: begin
                        mem_we   = 1'b1;
                        mem_addr = ind_addr;
                        mem_data = (opcode == cpu_pkg::op_mov && mov_imm) ? ir_low : acc;
                    end
                    cpu_pkg::op_stop: begin
                        out_ld     = 1'b1;
                        mem_addr   = opnd_addr(stop_opnd);
                        state_next = stop_state;
                    end
                    default: state_next = cpu_pkg::fetch;
                endcase
            end
            cpu_pkg::op2_ready: begin
                state_next = cpu_pkg::fetch;
                case (opcode)
                    cpu_pkg::op_mov: begin
                        mem_addr = opnd_addr(op1);
                        if (op1.indirect) begin
                            acc_ld     = 1'b1;
                            state_next = cpu_pkg::op1_ready;
                        end else begin
                            mem_we   = 1'b1;
                            mem_data = mem_in;
                        end
                    end
                    cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_mul: begin
                        acc_ld     = 1'b1;
                        mem_addr   = opnd_addr(op3);
                        state_next = rd_state(op3, cpu_pkg::op3_indirect, cpu_pkg::op3_ready);
                    end
                    cpu_pkg::op_stop: begin
                        out_ld     = 1'b1;
                        mem_addr   = opnd_addr(stop_opnd);
                        state_next = stop_state;
                    end
                    default: state_next = cpu_pkg::fetch;
                endcase
            end
            cpu_pkg::op3_ready: begin
                state_next = cpu_pkg::fetch;
                case (opcode)
                    cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_mul: begin
                        mem_addr = opnd_addr(op1);
                        if (op1.indirect) begin
                            acc_ld       = 1'b1;
                            acc_from_alu = 1'b1;
                            state_next   = cpu_pkg::op1_ready;
                        end else begin
                            mem_we   = 1'b1;
                            mem_data = alu_result;
                        end
                    end
                    cpu_pkg::op_stop: begin
                        out_ld     = 1'b1;
                        state_next = cpu_pkg::stopped;
                    end
                    default: state_next = cpu_pkg::fetch;
                endcase
            end
            cpu_pkg::second_word: begin
                ir_low_ld  = 1'b1;
                state_next = cpu_pkg::second_word_ready;
            end
            cpu_pkg::second_word_ready: begin
                mem_addr = opnd_addr(op1);
                if (op1.indirect) begin
                    state_next = cpu_pkg::op1_ready;
                end else begin
                    mem_we     = 1'b1;
                    mem_data   = ir_low;
                    state_next = cpu_pkg::fetch;
                end
            end
            cpu_pkg::stopped: state_next = cpu_pkg::stopped;
            default: state_next = cpu_pkg::fetch;
        endcase
    end

endmodule

//--- design/cpu_top.sv
`include "cpu_settings.svh"

module cpu_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`CPU_DATA_WIDTH-1:0] mem_in,
    input  logic [`CPU_DATA_WIDTH-1:0] in,
    output logic                       mem_we,
    output logic [`CPU_ADDR_WIDTH-1:0] mem_addr,
    output logic [`CPU_DATA_WIDTH-1:0] mem_data,
    output logic [`CPU_DATA_WIDTH-1:0] out,
    output logic [`CPU_ADDR_WIDTH-1:0] pc,
    output logic                       halted
);

    logic                       pc_inc;
    logic                       ir_ld;
    logic                       ir_low_ld;
    logic                       acc_ld;
    logic                       acc_from_alu;
    logic                       out_ld;
    cpu_pkg::instr_word_t       ir;
    logic [`CPU_DATA_WIDTH-1:0] ir_low;
    logic [`CPU_DATA_WIDTH-1:0] acc;
    logic [`CPU_DATA_WIDTH-1:0] alu_result;
    cpu_pkg::alu_op_e           alu_op;

    cpu_control u_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc           (pc),
        .ir           (ir),
        .ir_low       (ir_low),
        .acc          (acc),
        .mem_in       (mem_in),
        .in           (in),
        .alu_result   (alu_result),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .pc_inc       (pc_inc),
        .ir_ld        (ir_ld),
        .ir_low_ld    (ir_low_ld),
        .acc_ld       (acc_ld),
        .acc_from_alu (acc_from_alu),
        .out_ld       (out_ld),
        .alu_op       (alu_op),
        .halted       (halted)
    );

    cpu_regs u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc_inc       (pc_inc),
        .ir_ld        (ir_ld),
        .ir_low_ld    (ir_low_ld),
        .acc_ld       (acc_ld),
        .acc_from_alu (acc_from_alu),
        .out_ld       (out_ld),
        .mem_in       (mem_in),
        .alu_result   (alu_result),
        .pc           (pc),
        .ir           (ir),
        .ir_low       (ir_low),
        .acc          (acc),
        .out          (out)
    );

    // Operand two sits in acc, operand three arrives on mem_in
    cpu_alu u_alu (
        .op     (alu_op),
        .a      (acc),
        .b      (mem_in),
        .result (alu_result)
    );

endmodule

//--- tests/tb_memory.sv
`include "cpu_settings.svh"

module tb_memory (
    input  logic                       clk,
    input  logic                       we,
    input  logic [`CPU_ADDR_WIDTH-1:0] addr,
    input  logic [`CPU_DATA_WIDTH-1:0] wdata,
    output logic [`CPU_DATA_WIDTH-1:0] rdata
);

    // Whole address space preloaded by the testbench
    logic [`CPU_DATA_WIDTH-1:0] mem [0:(1 << `CPU_ADDR_WIDTH)-1];

    initial rdata = '0;

    // Writes land on the edge and read data shows up in the following cycle
    always @(posedge clk) begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];
    end

endmodule

//--- tests/cpu_asserts.sv
`include "cpu_settings.svh"

module cpu_asserts (
    input logic                       clk,
    input logic                       rst_n,
    input logic [`CPU_DATA_WIDTH-1:0] mem_in,
    input logic                       mem_we,
    input logic [`CPU_DATA_WIDTH-1:0] out,
    input logic [`CPU_ADDR_WIDTH-1:0] pc,
    input logic                       halted
);

    // Number of failed assertions so far
    int fail_count = 0;

    // Covers every reset cycle and the first cycle after release
    reset_values_a: assert property (@(posedge clk)
        !rst_n |=> (pc == `CPU_RESET_PC && out == '0 && !mem_we && !halted))
    else begin
        $error("reset values wrong, pc %0d out %h", pc, out);
        fail_count++;
    end

    pc_step_a: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(pc) |-> pc == $past(pc) + 1'b1)
    else begin
        $error("pc moved from %0d to %0d", $past(pc), pc);
        fail_count++;
    end

    pc_frozen_a: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> ($stable(pc) && halted))
    else begin
        $error("pc or halted changed after the halt");
        fail_count++;
    end

    // out only ever loads the word the memory returned
    out_source_a: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(out) |-> out == $past(mem_in))
    else begin
        $error("out became %h, memory returned %h", out, $past(mem_in));
        fail_count++;
    end

    no_write_halted_a: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !mem_we)
    else begin
        $error("memory write while halted");
        fail_count++;
    end

endmodule

bind cpu_top cpu_asserts u_asserts (
    .clk    (clk),
    .rst_n  (rst_n),
    .mem_in (mem_in),
    .mem_we (mem_we),
    .out    (out),
    .pc     (pc),
    .halted (halted)
);

//--- tests/tb_cpu.sv
`include "cpu_settings.svh"

module tb_cpu;

    localparam int reset_cycles   = 8;
    localparam int program_instrs = 11;
    localparam int cycle_limit    = reset_cycles + 40 * program_instrs;
    localparam int mem_words      = 1 << `CPU_ADDR_WIDTH;
    // pc value while each IN instruction writes
    localparam logic [`CPU_ADDR_WIDTH-1:0] in_direct_pc   = 6'd17;
    localparam logic [`CPU_ADDR_WIDTH-1:0] in_indirect_pc = 6'd18;

    logic                       clk;
    logic                       rst_n;
    logic [`CPU_DATA_WIDTH-1:0] mem_in;
    logic [`CPU_DATA_WIDTH-1:0] in_data;
    logic                       mem_we;
    logic [`CPU_ADDR_WIDTH-1:0] mem_addr;
    logic [`CPU_DATA_WIDTH-1:0] mem_data;
    logic [`CPU_DATA_WIDTH-1:0] out;
    logic [`CPU_ADDR_WIDTH-1:0] pc;
    logic                       halted;

    integer                     seed = 32'h24cd;
    logic [`CPU_DATA_WIDTH-1:0] image [0:mem_words-1];
    logic [`CPU_DATA_WIDTH-1:0] exp_mem [0:mem_words-1];
    logic [`CPU_DATA_WIDTH-1:0] outs [$];
    logic [`CPU_DATA_WIDTH-1:0] exp_outs [$];
    logic [`CPU_DATA_WIDTH-1:0] last_out;
    logic [`CPU_DATA_WIDTH-1:0] in_direct;
    logic [`CPU_DATA_WIDTH-1:0] in_indirect;

    cpu_top dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem_in   (mem_in),
        .in       (in_data),
        .mem_we   (mem_we),
        .mem_addr (mem_addr),
        .mem_data (mem_data),
        .out      (out),
        .pc       (pc),
        .halted   (halted)
    );

    tb_memory mem0 (
        .clk   (clk),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_data),
        .rdata (mem_in)
    );

    always #2 clk = ~clk;

    // Fresh input word every cycle
    always @(posedge clk)
        in_data <= $random(seed);

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        assert (got === expected)
        else fail_run($sformatf("error at %0t: %s is %0h, expected %0h",
                                $time, what, got, expected));
    endtask

    // Indirect operand, low address bits of the pointer word
    function automatic int ptr(input int a);
        return int'(exp_mem[a][`CPU_ADDR_WIDTH-1:0]);
    endfunction

    task automatic load_program();
        for (int i = 0; i < mem_words; i++)
            image[i] = 16'hC000 ^ (16'(i) * 16'h0101);
        // Operands and pointers, upper pointer bits are ignored
        image[0]  = 16'h12AA;
        image[2]  = 16'h1234;
        image[4]  = 16'h0068;
        image[5]  = 16'h0029;
        image[6]  = 16'h7001;
        image[7]  = 16'h0F0F;
        image[41] = 16'h0567;
        image[8]  = 16'h0120;
        image[9]  = 16'h0308;
        image[10] = 16'hBEEF;
        image[11] = 16'h0CD0;
        image[12] = 16'h1867;
        image[13] = 16'h26D7;
        image[14] = 16'h372C;
        image[15] = 16'h3C8D;
        image[16] = 16'h7200;
        image[17] = 16'h7D00;
        image[18] = 16'h8300;
        image[19] = 16'hF186;
        for (int i = 0; i < mem_words; i++)
            mem0.mem[i] = image[i];
    endtask

    // Instruction by instruction effect of the program above
    task automatic compute_expected();
        exp_mem = image;
        exp_mem[1] = exp_mem[2];
        exp_mem[3] = 16'hBEEF;
        exp_mem[ptr(4)] = exp_mem[ptr(5)];
        exp_mem[ptr(0)] = exp_mem[6] + exp_mem[7];
        exp_mem[6] = exp_mem[ptr(5)] - exp_mem[7];
        exp_mem[7] = exp_mem[2] * exp_mem[ptr(4)];
        exp_mem[ptr(4)] = exp_mem[ptr(0)] * exp_mem[ptr(5)];
        exp_mem[2] = in_direct;
        exp_mem[ptr(5)] = in_indirect;
        exp_outs = {exp_mem[3], exp_mem[1], exp_mem[ptr(0)], exp_mem[6]};
    endtask

    always @(negedge clk) begin
        if (rst_n && out !== last_out) begin
            outs.push_back(out);
            last_out = out;
        end
        if (rst_n && mem_we && pc == in_direct_pc)
            in_direct = in_data;
        if (rst_n && mem_we && pc == in_indirect_pc)
            in_indirect = in_data;
    end

    always @(negedge clk) begin
        if (dut0.u_asserts.fail_count != 0)
            fail_run("a port-level assertion on cpu_top failed");
    end

    initial begin
        repeat (cycle_limit) @(posedge clk);
        fail_run($sformatf("timeout: the CPU did not halt within %0d cycles", cycle_limit));
    end

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_data  = '0;
        last_out = '0;
        load_program();
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        do @(negedge clk); while (!halted);
        // A few more edges for the recorders and the halt assertions
        repeat (3) @(negedge clk);
        compute_expected();
        check_word("out count", outs.size(), exp_outs.size());
        foreach (exp_outs[i])
            check_word($sformatf("out #%0d", i), outs[i], exp_outs[i]);
        foreach (exp_mem[i])
            check_word($sformatf("mem[%0d]", i), mem0.mem[i], exp_mem[i]);
        if (dut0.u_asserts.fail_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            fail_run("a port-level assertion on cpu_top failed");
        end
    end

endmodule

//--- cpu.f
+incdir+common
common/cpu_pkg.sv
design/cpu_alu.sv
design/cpu_regs.sv
control/cpu_control.sv
design/cpu_top.sv
tests/tb_memory.sv
tests/cpu_asserts.sv
tests/tb_cpu.sv

//--- Bender.yml
package:
  name: cpu

export_include_dirs:
  - common

sources:
  - files:
      - common/cpu_pkg.sv
      - design/cpu_alu.sv
      - design/cpu_regs.sv
      - control/cpu_control.sv
      - design/cpu_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_memory.sv
      - tests/cpu_asserts.sv
      - tests/tb_cpu.sv
